/* dv/plic_tb.sv */
// Table-driven testbench for the interrupt controller with bus tasks, checks and timeout
`timescale 1ns/100ps
`default_nettype none

module plic_tb;

  // Short names for the register map
  localparam logic [7:0] PRIO = plic_reg_pkg::PRIO_BASE;
  localparam logic [7:0] IP   = plic_reg_pkg::IP_ADDR;
  localparam logic [7:0] LE   = plic_reg_pkg::LE_ADDR;
  localparam logic [7:0] IE   = plic_reg_pkg::IE_BASE;
  localparam logic [7:0] THR  = plic_reg_pkg::THR_BASE;
  localparam logic [7:0] CC   = plic_reg_pkg::CC_BASE;
  localparam logic [7:0] MSIP = plic_reg_pkg::MSIP_BASE;

  // Step kinds of the stimulus table
  typedef enum logic [2:0] {K_WR, K_RD, K_SRC, K_WAIT, K_IRQ} kind_e;

  // One table row
  // Irq and msip columns are per-target bit masks
  typedef struct packed {
    kind_e       kind;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [1:0]  exp_irq;
    logic [2:0]  exp_id0;
    logic [2:0]  exp_id1;
    logic [1:0]  exp_msip;
  } step_t;

  logic                   clk;
  logic                   rst;
  plic_bus_pkg::bus_req_t bus_req;
  plic_bus_pkg::bus_rsp_t bus_rsp;
  logic [7:0]             intr_src;
  logic [1:0]             irq;
  plic_reg_pkg::id_t      irq_id [2];
  logic [1:0]             msip;

  step_t table_q [$];
  int    mismatches = 0;
  int    other_errs = 0;
  int    cycles     = 0;
  int    limit      = 0;

  plic_top dut0 (
    .clk_i      (clk),
    .rst_i      (rst),
    .bus_req_i  (bus_req),
    .bus_rsp_o  (bus_rsp),
    .intr_src_i (intr_src),
    .irq_o      (irq),
    .irq_id_o   (irq_id),
    .msip_o     (msip)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Argument order is kind, addr, data, rdata, err, irq, id0, id1, msip
  function automatic step_t make_step(input kind_e kind, input logic [7:0] addr,
                                      input logic [31:0] data, input logic [31:0] rdata,
                                      input int err, input int irq_m, input int id0,
                                      input int id1, input int msip_m);
    step_t s;
    s.kind      = kind;
    s.addr      = addr;
    s.data      = data;
    s.exp_rdata = rdata;
    s.exp_err   = 1'(err);
    s.exp_irq   = 2'(irq_m);
    s.exp_id0   = 3'(id0);
    s.exp_id1   = 3'(id1);
    s.exp_msip  = 2'(msip_m);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    assert (act === exp) else begin
      mismatches++;
      $display("MISMATCH %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    end
  endtask

  // Request driven on a falling edge
  // Response registered at the next rising edge
  task automatic bus_xfer(input plic_bus_pkg::bus_op_e op, input logic [7:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    bus_req.valid = 1'b1;
    bus_req.op    = op;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    @(negedge clk);
    // One request edge only
    bus_req.valid = 1'b0;
    assert (bus_rsp.valid) else begin
      other_errs++;
      $display("%0t: no bus response one cycle after the request to address 0x%02h",
               $time, addr);
    end
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  initial begin
    // Reset values and register access
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, PRIO + 8'd1, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, IP, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, LE, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, IE, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, THR + 8'd1, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, MSIP, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, PRIO + 8'd1, 5, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, PRIO + 8'd1, 0, 5, 0, 0, 0, 0, 0));
    // Priority above the top level clips to 7
    table_q.push_back(make_step(K_WR, PRIO + 8'd2, 9, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, PRIO + 8'd2, 0, 7, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, LE, 'hA5, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, LE, 0, 'hA5, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, LE, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE + 8'd1, 'hFF, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, IE + 8'd1, 0, 'hFF, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE + 8'd1, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, THR + 8'd1, 3, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, THR + 8'd1, 0, 3, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, THR + 8'd1, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, MSIP + 8'd1, 1, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, MSIP + 8'd1, 0, 1, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 2));
    // Software bits of the two targets move apart
    table_q.push_back(make_step(K_WR, MSIP, 1, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, MSIP + 8'd1, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, MSIP, 0, 1, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 1));
    table_q.push_back(make_step(K_WR, MSIP, 0, 0, 0, 0, 0, 0, 0));
    // Unmapped addresses
    table_q.push_back(make_step(K_RD, 8'h50, 0, 0, 1, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, 8'h7F, 1, 0, 1, 0, 0, 0, 0));
    // Level source 3 with claim, held level and complete
    table_q.push_back(make_step(K_WR, PRIO + 8'd3, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE, 'h08, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 'h08, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 3, 0, 0));
    table_q.push_back(make_step(K_RD, IP, 0, 'h08, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 3, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WAIT, 0, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 3, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 3, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 3, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 3, 0, 0, 0, 0, 0, 0));
    // Arbitration between sources 3 and 5
    table_q.push_back(make_step(K_WR, PRIO + 8'd5, 6, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE, 'h28, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 'h28, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 5, 0, 0));
    table_q.push_back(make_step(K_RD, IP, 0, 'h28, 0, 0, 0, 0, 0));
    // Tie goes to the lower ID
    table_q.push_back(make_step(K_WR, PRIO + 8'd5, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 3, 0, 0));
    table_q.push_back(make_step(K_WR, THR, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, THR, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 3, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 3, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 5, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 5, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 3, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 5, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    // Edge source 6 with a one-cycle pulse
    table_q.push_back(make_step(K_WR, LE, 'h40, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, PRIO + 8'd6, 2, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE, 'h40, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 'h40, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 6, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 6, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 6, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WAIT, 0, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    // A new rising edge held high still gives one interrupt
    table_q.push_back(make_step(K_SRC, 0, 'h40, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 6, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 6, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 6, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WAIT, 0, 4, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, LE, 0, 0, 0, 0, 0, 0, 0));
    // Source 7 on target 0 and source 2 on target 1
    table_q.push_back(make_step(K_WR, PRIO + 8'd7, 3, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, PRIO + 8'd2, 5, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE, 'h80, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, IE + 8'd1, 'h04, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 'h80, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 7, 0, 0));
    table_q.push_back(make_step(K_SRC, 0, 'h84, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 3, 7, 2, 0));
    table_q.push_back(make_step(K_RD, CC + 8'd1, 0, 2, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 1, 7, 0, 0));
    table_q.push_back(make_step(K_RD, CC, 0, 7, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    // Held source 2 comes back on target 1 only
    table_q.push_back(make_step(K_WR, CC + 8'd1, 2, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 2, 0, 2, 0));
    table_q.push_back(make_step(K_SRC, 0, 0, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_RD, CC + 8'd1, 0, 2, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC + 8'd1, 2, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_WR, CC, 7, 0, 0, 0, 0, 0, 0));
    table_q.push_back(make_step(K_IRQ, 0, 0, 0, 0, 0, 0, 0, 0));
    limit = table_q.size() * 8 + 50;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: stimulus table still running after %0d cycles", cycles);
    $display("errors: mismatches=%0d other=%0d", mismatches, other_errs + 1);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // Apply the table
  //////////////////////////////

  initial begin
    step_t       st;
    logic [31:0] rdata;
    logic        err;
    rst      = 1'b1;
    bus_req  = '0;
    intr_src = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    foreach (table_q[i]) begin
      st = table_q[i];
      case (st.kind)
        K_WR: begin
          bus_xfer(plic_bus_pkg::BUS_WRITE, st.addr, st.data, rdata, err);
          check_value("bus_rsp_o.err", 32'(err), 32'(st.exp_err));
        end
        K_RD: begin
          bus_xfer(plic_bus_pkg::BUS_READ, st.addr, st.data, rdata, err);
          check_value("bus_rsp_o.rdata", rdata, st.exp_rdata);
          check_value("bus_rsp_o.err", 32'(err), 32'(st.exp_err));
        end
        K_SRC: begin
          intr_src = st.data[7:0];
          @(negedge clk);
        end
        K_WAIT: begin
          repeat (st.data) @(negedge clk);
        end
        K_IRQ: begin
          // Source to irq is two edges
          repeat (2) @(negedge clk);
          check_value("irq_o", 32'(irq), 32'(st.exp_irq));
          check_value("irq_id_o[0]", 32'(irq_id[0]), 32'(st.exp_id0));
          check_value("irq_id_o[1]", 32'(irq_id[1]), 32'(st.exp_id1));
          check_value("msip_o", 32'(msip), 32'(st.exp_msip));
        end
        default: begin
          other_errs++;
          $display("%0t: unknown step kind in row %0d", $time, i);
        end
      endcase
    end
    $display("errors: mismatches=%0d other=%0d", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module plic_tb -f tb.f -o plic_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/plic_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* src/plic_bus_pkg.sv */
// Register bus request and response structs, bus opcode enum
`default_nettype none

package plic_bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Word address space of the controller
  localparam int unsigned ADDR_W = 8;
  // Register data width
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  //////////////////////////////
  // Opcodes and transfers
  //////////////////////////////

  // Single bit opcode
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // Request, sampled on every clock edge with valid high
  typedef struct packed {
    logic    valid;
    bus_op_e op;
    addr_t   addr;
    data_t   wdata;
  } bus_req_t;

  // Response, one cycle after the request
  typedef struct packed {
    logic  valid;
    data_t rdata;
    logic  err;   // Unmapped address
  } bus_rsp_t;

endpackage

`default_nettype wire

/* src/plic_gateway.sv */
// Per-source level and edge gateways with pending and in-service tracking
`timescale 1ns/100ps
`default_nettype none

module plic_gateway #(
  parameter int NumSrc = 8
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [NumSrc-1:0] src_i,
  input  logic [NumSrc-1:0] le_i,
  input  logic [NumSrc-1:0] claim_i,
  input  logic [NumSrc-1:0] complete_i,
  output logic [NumSrc-1:0] ip_o
);

  for (genvar s = 0; s < NumSrc; s++) begin : gen_src
    plic_reg_pkg::gw_state_e state_q;
    plic_reg_pkg::gw_state_e state_d;
    logic src_q;
    logic rise;
    logic req;
    logic extra_q;
    logic extra_d;

    // Rising edge against last sampled source
    assign rise = src_i[s] & ~src_q;
    // Edge mode also takes a queued edge
    assign req  = le_i[s] ? (rise | extra_q) : src_i[s];

    always_comb begin
      state_d = state_q;
      extra_d = extra_q;
      unique case (state_q)
        plic_reg_pkg::GW_IDLE: begin
          if (req) begin
            state_d = plic_reg_pkg::GW_PENDING;
            extra_d = 1'b0;
          end
        end
        plic_reg_pkg::GW_PENDING: begin
          if (claim_i[s]) begin
            state_d = plic_reg_pkg::GW_SERVICE;
          end
          // Hold one further edge
          if (le_i[s] && rise) begin
            extra_d = 1'b1;
          end
        end
        plic_reg_pkg::GW_SERVICE: begin
          if (complete_i[s]) begin
            state_d = plic_reg_pkg::GW_IDLE;
          end
          if (le_i[s] && rise) begin
            extra_d = 1'b1;
          end
        end
        default: state_d = plic_reg_pkg::GW_IDLE;
      endcase
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        state_q <= plic_reg_pkg::GW_IDLE;
        src_q   <= 1'b0;
        extra_q <= 1'b0;
      end else begin
        state_q <= state_d;
        src_q   <= src_i[s];
        extra_q <= extra_d;
      end
    end

    assign ip_o[s] = (state_q == plic_reg_pkg::GW_PENDING);
  end

endmodule

`default_nettype wire

/* src/plic_reg_decode.sv */
// Register file and bus decoder with claim and complete strobe generation
`timescale 1ns/100ps
`default_nettype none

module plic_reg_decode #(
  parameter int NumSrc    = 8,
  parameter int NumTarget = 2,
  parameter int MaxPrio   = 7
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  plic_bus_pkg::bus_req_t bus_req_i,
  output plic_bus_pkg::bus_rsp_t bus_rsp_o,
  input  logic [NumSrc-1:0]      ip_i,
  input  plic_reg_pkg::id_t      irq_id_i [NumTarget],
  output plic_reg_pkg::prio_t    prio_o [NumSrc],
  output logic [NumSrc-1:0]      le_o,
  output logic [NumSrc-1:0]      ie_o [NumTarget],
  output plic_reg_pkg::prio_t    threshold_o [NumTarget],
  output logic [NumTarget-1:0]   msip_o,
  output logic [NumSrc-1:0]      claim_o,
  output logic [NumSrc-1:0]      complete_o
);

  // Register state
  plic_reg_pkg::prio_t    prio_q [NumSrc];
  logic [NumSrc-1:0]      le_q;
  logic [NumSrc-1:0]      ie_q [NumTarget];
  plic_reg_pkg::prio_t    thr_q [NumTarget];
  logic [NumTarget-1:0]   msip_q;
  plic_bus_pkg::bus_rsp_t rsp_q;

  // Decode results
  logic                rd_en;
  logic                wr_en;
  logic                mapped;
  plic_bus_pkg::data_t rdata_d;
  plic_reg_pkg::id_t   cc_wr_id;
  logic                cc_wr_ok;

  assign rd_en = bus_req_i.valid && (bus_req_i.op == plic_bus_pkg::BUS_READ);
  assign wr_en = bus_req_i.valid && (bus_req_i.op == plic_bus_pkg::BUS_WRITE);

  // Complete ID from write data, 0 and out of range are dropped
  assign cc_wr_id = plic_reg_pkg::id_t'(bus_req_i.wdata);
  assign cc_wr_ok = (bus_req_i.wdata != '0) &&
                    (bus_req_i.wdata < plic_bus_pkg::data_t'(NumSrc));

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb begin
    mapped     = 1'b0;
    rdata_d    = '0;
    claim_o    = '0;
    complete_o = '0;
    if (bus_req_i.addr == plic_reg_pkg::IP_ADDR) begin
      mapped  = 1'b1;
      rdata_d = plic_bus_pkg::data_t'(ip_i);
    end
    if (bus_req_i.addr == plic_reg_pkg::LE_ADDR) begin
      mapped  = 1'b1;
      rdata_d = plic_bus_pkg::data_t'(le_q);
    end
    for (int s = 0; s < NumSrc; s++) begin
      if (bus_req_i.addr == plic_reg_pkg::PRIO_BASE + 8'(s)) begin
        mapped  = 1'b1;
        rdata_d = plic_bus_pkg::data_t'(prio_q[s]);
      end
    end
    for (int t = 0; t < NumTarget; t++) begin
      if (bus_req_i.addr == plic_reg_pkg::IE_BASE + 8'(t)) begin
        mapped  = 1'b1;
        rdata_d = plic_bus_pkg::data_t'(ie_q[t]);
      end
      if (bus_req_i.addr == plic_reg_pkg::THR_BASE + 8'(t)) begin
        mapped  = 1'b1;
        rdata_d = plic_bus_pkg::data_t'(thr_q[t]);
      end
      if (bus_req_i.addr == plic_reg_pkg::MSIP_BASE + 8'(t)) begin
        mapped  = 1'b1;
        rdata_d = plic_bus_pkg::data_t'(msip_q[t]);
      end
      if (bus_req_i.addr == plic_reg_pkg::CC_BASE + 8'(t)) begin
        mapped  = 1'b1;
        // Read returns the arbiter ID seen at the request edge
        rdata_d = plic_bus_pkg::data_t'(irq_id_i[t]);
        // Claim strobe in the request cycle
        if (rd_en && (irq_id_i[t] != '0)) begin
          claim_o[irq_id_i[t]] = 1'b1;
        end
        if (wr_en && cc_wr_ok) begin
          complete_o[cc_wr_id] = 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Register writes
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < NumSrc; s++) begin
        prio_q[s] <= '0;
      end
      for (int t = 0; t < NumTarget; t++) begin
        ie_q[t]  <= '0;
        thr_q[t] <= '0;
      end
      le_q   <= '0;
      msip_q <= '0;
    end else if (wr_en) begin
      if (bus_req_i.addr == plic_reg_pkg::LE_ADDR) begin
        le_q <= bus_req_i.wdata[NumSrc-1:0];
      end
      for (int s = 0; s < NumSrc; s++) begin
        if (bus_req_i.addr == plic_reg_pkg::PRIO_BASE + 8'(s)) begin
          // Saturate at the top priority
          if (bus_req_i.wdata > plic_bus_pkg::data_t'(MaxPrio)) begin
            prio_q[s] <= plic_reg_pkg::prio_t'(MaxPrio);
          end else begin
            prio_q[s] <= plic_reg_pkg::prio_t'(bus_req_i.wdata);
          end
        end
      end
      for (int t = 0; t < NumTarget; t++) begin
        if (bus_req_i.addr == plic_reg_pkg::IE_BASE + 8'(t)) begin
          ie_q[t] <= bus_req_i.wdata[NumSrc-1:0];
        end
        if (bus_req_i.addr == plic_reg_pkg::THR_BASE + 8'(t)) begin
          thr_q[t] <= plic_reg_pkg::prio_t'(bus_req_i.wdata);
        end
        if (bus_req_i.addr == plic_reg_pkg::MSIP_BASE + 8'(t)) begin
          msip_q[t] <= bus_req_i.wdata[0];
        end
      end
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    // Read data only, writes return zero
    rsp_q.rdata <= rd_en ? rdata_d : '0;
    if (rst_i) begin
      rsp_q.valid <= 1'b0;
      rsp_q.err   <= 1'b0;
    end else begin
      rsp_q.valid <= bus_req_i.valid;
      rsp_q.err   <= bus_req_i.valid && !mapped;
    end
  end

  assign bus_rsp_o   = rsp_q;
  assign prio_o      = prio_q;
  assign le_o        = le_q;
  assign ie_o        = ie_q;
  assign threshold_o = thr_q;
  assign msip_o      = msip_q;

endmodule

`default_nettype wire

/* src/plic_reg_pkg.sv */
// Register map offsets, gateway state enum, priority and ID widths
`default_nettype none

package plic_reg_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  // Covers MaxPrio up to 7
  localparam int unsigned PRIO_W = 3;
  // Covers up to 8 sources
  localparam int unsigned ID_W   = 3;

  typedef logic [PRIO_W-1:0] prio_t;
  typedef logic [ID_W-1:0]   id_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Word offsets on the register bus
  // Priority of source s
  localparam logic [7:0] PRIO_BASE = 8'h00;
  // Pending word, read only
  localparam logic [7:0] IP_ADDR   = 8'h08;
  // Trigger mode word, 1 means edge
  localparam logic [7:0] LE_ADDR   = 8'h09;
  // Enable word of target t
  localparam logic [7:0] IE_BASE   = 8'h10;
  // Threshold of target t
  localparam logic [7:0] THR_BASE  = 8'h20;
  // Claim on read, complete on write
  localparam logic [7:0] CC_BASE   = 8'h30;
  // Software interrupt bit of target t
  localparam logic [7:0] MSIP_BASE = 8'h40;

  //////////////////////////////
  // Gateway FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    GW_IDLE    = 2'd0,
    GW_PENDING = 2'd1,
    GW_SERVICE = 2'd2
  } gw_state_e;

endpackage

`default_nettype wire

/* src/plic_target.sv */
// Per-target priority arbiter with threshold compare and registered irq
`timescale 1ns/100ps
`default_nettype none

module plic_target #(
  parameter int NumSrc  = 8,
  parameter int MaxPrio = 7
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NumSrc-1:0]   ip_i,
  input  logic [NumSrc-1:0]   ie_i,
  input  plic_reg_pkg::prio_t prio_i [NumSrc],
  input  plic_reg_pkg::prio_t threshold_i,
  output logic                irq_o,
  output plic_reg_pkg::id_t   irq_id_o
);

  // Candidates are pending and enabled
  logic [NumSrc-1:0]   cand;
  logic                found;
  plic_reg_pkg::prio_t best_prio;
  plic_reg_pkg::id_t   best_id;
  logic                irq_d;
  plic_reg_pkg::id_t   irq_id_d;
  logic                irq_q;
  plic_reg_pkg::id_t   irq_id_q;

  assign cand = ip_i & ie_i;

  //////////////////////////////
  // Selection
  //////////////////////////////

  // Scan levels from the top down
  // Lowest ID wins inside one level
  // Level 0 never beats any threshold
  always_comb begin
    found     = 1'b0;
    best_prio = '0;
    best_id   = '0;
    for (int p = MaxPrio; p > 0; p--) begin
      for (int s = 0; s < NumSrc; s++) begin
        if (!found && cand[s] && (prio_i[s] == plic_reg_pkg::prio_t'(p))) begin
          found     = 1'b1;
          best_prio = plic_reg_pkg::prio_t'(p);
          best_id   = plic_reg_pkg::id_t'(s);
        end
      end
    end
  end

  // Strictly above threshold
  always_comb begin
    irq_d    = found && (best_prio > threshold_i);
    irq_id_d = irq_d ? best_id : '0;
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_q    <= 1'b0;
      irq_id_q <= '0;
    end else begin
      irq_q    <= irq_d;
      irq_id_q <= irq_id_d;
    end
  end

  assign irq_o    = irq_q;
  assign irq_id_o = irq_id_q;

endmodule

`default_nettype wire

/* src/plic_top.sv */
// Interrupt controller top level joining decoder, gateways and arbiters
`timescale 1ns/100ps
`default_nettype none

module plic_top #(
  parameter int NumSrc    = 8,
  parameter int NumTarget = 2,
  parameter int MaxPrio   = 7
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  plic_bus_pkg::bus_req_t bus_req_i,
  output plic_bus_pkg::bus_rsp_t bus_rsp_o,
  input  logic [NumSrc-1:0]      intr_src_i,
  output logic [NumTarget-1:0]   irq_o,
  output plic_reg_pkg::id_t      irq_id_o [NumTarget],
  output logic [NumTarget-1:0]   msip_o
);

  plic_reg_pkg::prio_t prio [NumSrc];
  plic_reg_pkg::prio_t threshold [NumTarget];
  logic [NumSrc-1:0]   ie [NumTarget];
  logic [NumSrc-1:0]   le;
  logic [NumSrc-1:0]   ip;
  logic [NumSrc-1:0]   claim;
  logic [NumSrc-1:0]   complete;
  logic [NumSrc-1:0]   src;

  // Source 0 is reserved
  assign src = {intr_src_i[NumSrc-1:1], 1'b0};

  //////////////////////////////
  // Registers and gateways
  //////////////////////////////

  plic_reg_decode #(
    .NumSrc    (NumSrc),
    .NumTarget (NumTarget),
    .MaxPrio   (MaxPrio)
  ) u_reg (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .ip_i        (ip),
    .irq_id_i    (irq_id_o),
    .prio_o      (prio),
    .le_o        (le),
    .ie_o        (ie),
    .threshold_o (threshold),
    .msip_o      (msip_o),
    .claim_o     (claim),
    .complete_o  (complete)
  );

  plic_gateway #(
    .NumSrc (NumSrc)
  ) u_gateway (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .src_i      (src),
    .le_i       (le),
    .claim_i    (claim),
    .complete_i (complete),
    .ip_o       (ip)
  );

  // One arbiter per target
  for (genvar t = 0; t < NumTarget; t++) begin : gen_target
    plic_target #(
      .NumSrc  (NumSrc),
      .MaxPrio (MaxPrio)
    ) u_target (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ip_i        (ip),
      .ie_i        (ie[t]),
      .prio_i      (prio),
      .threshold_i (threshold[t]),
      .irq_o       (irq_o[t]),
      .irq_id_o    (irq_id_o[t])
    );
  end

endmodule

`default_nettype wire

/* tb.f */
src/plic_bus_pkg.sv
src/plic_reg_pkg.sv
src/plic_reg_decode.sv
src/plic_gateway.sv
src/plic_target.sv
src/plic_top.sv
dv/plic_tb.sv
